/* design/bus_decoder.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module bus_decoder (
    input  logic            clk_i,
    input  logic            ndmreset_n,
    input  logic            req_i,
    input  logic            we_i,
    input  bus_pkg::word_t  addr_i,
    input  bus_pkg::word_t  wdata_i,
    output logic            gnt_o,
    output logic            rvalid_o,
    output bus_pkg::word_t  rdata_o,
    output logic            err_o,
    output logic            ext_req_o,
    output logic            ext_we_o,
    output bus_pkg::word_t  ext_addr_o,
    output bus_pkg::word_t  ext_wdata_o,
    input  logic            ext_rvalid_i,
    input  bus_pkg::word_t  ext_rdata_i,
    periph_bus_if.initiator clint_bus,
    periph_bus_if.initiator plic_bus
);

    bus_pkg::region_e region;
    bus_pkg::region_e region_q;
    bus_pkg::word_t   clint_off;
    bus_pkg::word_t   plic_off;
    bus_pkg::word_t   ext_off;
    logic             accept;
    logic             outstanding_q;
    logic             err_pending_q;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------
    assign clint_off = addr_i - `SOC_CLINT_BASE;
    assign plic_off  = addr_i - `SOC_PLIC_BASE;
    assign ext_off   = addr_i - `SOC_EXT_BASE;

    always_comb begin
        if (clint_off < `SOC_CLINT_LEN) begin
            region = bus_pkg::REGION_CLINT;
        end else if (plic_off < `SOC_PLIC_LEN) begin
            region = bus_pkg::REGION_PLIC;
        end else if (ext_off < `SOC_EXT_LEN) begin
            region = bus_pkg::REGION_EXT;
        end else begin
            region = bus_pkg::REGION_NONE;
        end
    end

    // Single transaction in flight
    assign gnt_o  = ~outstanding_q;
    assign accept = req_i & gnt_o;

    assign clint_bus.req   = accept && (region == bus_pkg::REGION_CLINT);
    assign clint_bus.we    = we_i;
    assign clint_bus.addr  = addr_i;
    assign clint_bus.wdata = wdata_i;

    assign plic_bus.req    = accept && (region == bus_pkg::REGION_PLIC);
    assign plic_bus.we     = we_i;
    assign plic_bus.addr   = addr_i;
    assign plic_bus.wdata  = wdata_i;

    // External port sees the request fields unchanged
    assign ext_req_o   = accept && (region == bus_pkg::REGION_EXT);
    assign ext_we_o    = we_i;
    assign ext_addr_o  = addr_i;
    assign ext_wdata_o = wdata_i;

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            outstanding_q <= 1'b0;
            region_q      <= bus_pkg::REGION_NONE;
            err_pending_q <= 1'b0;
        end else begin
            err_pending_q <= accept && (region == bus_pkg::REGION_NONE);
            if (accept) begin
                outstanding_q <= 1'b1;
                region_q      <= region;
            end else if (rvalid_o) begin
                outstanding_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Response return by recorded region
    // ----------------------------------------------------------------------
    always_comb begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
        err_o    = 1'b0;
        if (outstanding_q) begin
            unique case (region_q)
                bus_pkg::REGION_CLINT: begin
                    rvalid_o = clint_bus.rvalid;
                    rdata_o  = clint_bus.rdata;
                end
                bus_pkg::REGION_PLIC: begin
                    rvalid_o = plic_bus.rvalid;
                    rdata_o  = plic_bus.rdata;
                end
                bus_pkg::REGION_EXT: begin
                    rvalid_o = ext_rvalid_i;
                    rdata_o  = ext_rdata_i;
                end
                bus_pkg::REGION_NONE: begin
                    rvalid_o = err_pending_q;
                    err_o    = err_pending_q;
                end
            endcase
        end
    end

endmodule

/* design/bus_pkg.sv */
`include "soc_cfg.svh"

package bus_pkg;

    // One bus word, used for both address and data
    typedef logic [`SOC_XLEN-1:0] word_t;

    // Target picked by the address decoder
    typedef enum logic [1:0] {
        REGION_CLINT = 2'd0,
        REGION_PLIC  = 2'd1,
        REGION_EXT   = 2'd2,
        REGION_NONE  = 2'd3
    } region_e;

    // 64-bit timer value, counted as a whole and accessed by word
    typedef union packed {
        logic [2*`SOC_XLEN-1:0] count;
        struct packed {
            word_t hi;
            word_t lo;
        } word;
    } dword_u;

endpackage

/* design/clint.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module clint (
    input  logic         clk_i,
    input  logic         ndmreset_n,
    periph_bus_if.target bus,
    output logic         timer_irq_o,
    output logic         ipi_o
);

    logic            tick_q;
    logic            msip_q;
    logic            wr;
    bus_pkg::dword_u mtime_q;
    bus_pkg::dword_u mtimecmp_q;
    bus_pkg::word_t  off;
    bus_pkg::word_t  rd_word;

    assign off = bus.addr - `SOC_CLINT_BASE;
    assign wr  = bus.req & bus.we;

    // Real-time tick at half the clock rate
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            tick_q <= 1'b0;
        end else begin
            tick_q <= ~tick_q;
        end
    end

    // ----------------------------------------------------------------------
    // Timer and software interrupt registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
        end else begin
            // A software write wins over the tick
            if (wr && (off == `SOC_CLINT_MTIME_LO)) begin
                mtime_q.word.lo <= bus.wdata;
            end else if (wr && (off == `SOC_CLINT_MTIME_HI)) begin
                mtime_q.word.hi <= bus.wdata;
            end else if (tick_q) begin
                mtime_q.count <= mtime_q.count + 1'b1;
            end

            if (wr) begin
                case (off)
                    `SOC_CLINT_MSIP:        msip_q             <= bus.wdata[0];
                    `SOC_CLINT_MTIMECMP_LO: mtimecmp_q.word.lo <= bus.wdata;
                    `SOC_CLINT_MTIMECMP_HI: mtimecmp_q.word.hi <= bus.wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (off)
            `SOC_CLINT_MSIP:        rd_word = {{(`SOC_XLEN-1){1'b0}}, msip_q};
            `SOC_CLINT_MTIMECMP_LO: rd_word = mtimecmp_q.word.lo;
            `SOC_CLINT_MTIMECMP_HI: rd_word = mtimecmp_q.word.hi;
            `SOC_CLINT_MTIME_LO:    rd_word = mtime_q.word.lo;
            `SOC_CLINT_MTIME_HI:    rd_word = mtime_q.word.hi;
            default:                rd_word = '0;
        endcase
    end

    // Every access answered one cycle later
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= bus.req;
        end
    end

    always_ff @(posedge clk_i) begin
        bus.rdata <= (bus.req && !bus.we) ? rd_word : '0;
    end

    assign timer_irq_o = (mtime_q.count >= mtimecmp_q.count);
    assign ipi_o       = msip_q;

endmodule

/* design/intr_pkg.sv */
`include "soc_cfg.svh"

package intr_pkg;

    // One bit per source, bit 0 is the reserved source
    typedef logic [`SOC_NUM_SOURCES-1:0] src_vec_t;

    // Source number as returned by a claim
    typedef logic [$clog2(`SOC_NUM_SOURCES)-1:0] src_id_t;

    typedef logic [`SOC_PRIO_W-1:0] prio_t;

endpackage

/* design/periph_bus_if.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

interface periph_bus_if;

    // Request, valid for one cycle per access
    logic           req;
    logic           we;
    bus_pkg::word_t addr;
    bus_pkg::word_t wdata;

    // Response, always one cycle after req
    logic           rvalid;
    bus_pkg::word_t rdata;

    modport initiator (
        output req, we, addr, wdata,
        input  rvalid, rdata
    );

    modport target (
        input  req, we, addr, wdata,
        output rvalid, rdata
    );

endinterface

/* design/periph_subsystem.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module periph_subsystem (
    input  logic               clk_i,
    input  logic               ndmreset_n,

    // Core-side master port
    input  logic               req_i,
    input  logic               we_i,
    input  bus_pkg::word_t     addr_i,
    input  bus_pkg::word_t     wdata_i,
    output logic               gnt_o,
    output logic               rvalid_o,
    output bus_pkg::word_t     rdata_o,
    output logic               err_o,

    // External port
    output logic               ext_req_o,
    output logic               ext_we_o,
    output bus_pkg::word_t     ext_addr_o,
    output bus_pkg::word_t     ext_wdata_o,
    input  logic               ext_rvalid_i,
    input  bus_pkg::word_t     ext_rdata_i,

    // Interrupts
    input  intr_pkg::src_vec_t irq_sources_i,
    output logic               timer_irq_o,
    output logic               ipi_o,
    output logic               eip_o
);

    periph_bus_if clint_bus ();
    periph_bus_if plic_bus ();

    // ----------------------------------------------------------------------
    // Decoder
    // ----------------------------------------------------------------------
    bus_decoder u_decoder (
        .clk_i        (clk_i),
        .ndmreset_n   (ndmreset_n),
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .gnt_o        (gnt_o),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .err_o        (err_o),
        .ext_req_o    (ext_req_o),
        .ext_we_o     (ext_we_o),
        .ext_addr_o   (ext_addr_o),
        .ext_wdata_o  (ext_wdata_o),
        .ext_rvalid_i (ext_rvalid_i),
        .ext_rdata_i  (ext_rdata_i),
        .clint_bus    (clint_bus.initiator),
        .plic_bus     (plic_bus.initiator)
    );

    // ----------------------------------------------------------------------
    // Interrupt controllers
    // ----------------------------------------------------------------------
    clint u_clint (
        .clk_i       (clk_i),
        .ndmreset_n  (ndmreset_n),
        .bus         (clint_bus.target),
        .timer_irq_o (timer_irq_o),
        .ipi_o       (ipi_o)
    );

    plic u_plic (
        .clk_i         (clk_i),
        .ndmreset_n    (ndmreset_n),
        .bus           (plic_bus.target),
        .irq_sources_i (irq_sources_i),
        .eip_o         (eip_o)
    );

endmodule

/* design/plic.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module plic (
    input  logic               clk_i,
    input  logic               ndmreset_n,
    periph_bus_if.target       bus,
    input  intr_pkg::src_vec_t irq_sources_i,
    output logic               eip_o
);

    localparam int unsigned N   = `SOC_NUM_SOURCES;
    localparam int unsigned IDW = $bits(intr_pkg::src_id_t);

    intr_pkg::prio_t    prio_q [N];
    intr_pkg::prio_t    threshold_q;
    intr_pkg::prio_t    best_prio;
    intr_pkg::src_vec_t enable_q;
    intr_pkg::src_vec_t pending_q;
    intr_pkg::src_vec_t active_q;
    intr_pkg::src_id_t  winner;
    intr_pkg::src_id_t  prio_idx;
    intr_pkg::src_id_t  cmpl_id;
    bus_pkg::word_t     off;
    bus_pkg::word_t     prio_off;
    bus_pkg::word_t     rd_word;
    logic               wr;
    logic               prio_hit;
    logic               claim_rd;
    logic               cmpl_wr;

    // ----------------------------------------------------------------------
    // Register decode
    // ----------------------------------------------------------------------
    assign off      = bus.addr - `SOC_PLIC_BASE;
    assign prio_off = off - `SOC_PLIC_PRIO;
    assign prio_hit = (prio_off < (4 * N));
    assign prio_idx = prio_off[2 +: IDW];

    assign wr       = bus.req & bus.we;
    assign claim_rd = bus.req && !bus.we && (off == `SOC_PLIC_CLAIM);
    assign cmpl_wr  = wr && (off == `SOC_PLIC_CLAIM);
    assign cmpl_id  = bus.wdata[IDW-1:0];

    // ----------------------------------------------------------------------
    // Arbitration
    // ----------------------------------------------------------------------
    // Strict compare keeps the lowest id on a tie and drops anything at threshold
    always_comb begin
        winner    = '0;
        best_prio = threshold_q;
        for (int i = 1; i < N; i++) begin
            if (pending_q[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                winner    = intr_pkg::src_id_t'(i);
                best_prio = prio_q[i];
            end
        end
    end

    assign eip_o = (winner != '0);

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            for (int i = 0; i < N; i++) begin
                prio_q[i] <= '0;
            end
            threshold_q <= '0;
            enable_q    <= '0;
            pending_q   <= '0;
            active_q    <= '0;
        end else begin
            // Gateways, a high level pends unless that source is in service
            pending_q <= pending_q | (irq_sources_i & ~active_q & ~intr_pkg::src_vec_t'(1));

            if (claim_rd && (winner != '0)) begin
                pending_q[winner] <= 1'b0;
                active_q[winner]  <= 1'b1;
            end
            if (cmpl_wr) begin
                active_q[cmpl_id] <= 1'b0;
            end

            if (wr && prio_hit) begin
                prio_q[prio_idx] <= bus.wdata[`SOC_PRIO_W-1:0];
            end
            if (wr && (off == `SOC_PLIC_ENABLE)) begin
                enable_q <= bus.wdata[N-1:0];
            end
            if (wr && (off == `SOC_PLIC_THRESHOLD)) begin
                threshold_q <= bus.wdata[`SOC_PRIO_W-1:0];
            end
        end
    end

    // Read data
    always_comb begin
        rd_word = '0;
        if (prio_hit) begin
            rd_word[`SOC_PRIO_W-1:0] = prio_q[prio_idx];
        end else begin
            case (off)
                `SOC_PLIC_PENDING:   rd_word[N-1:0]           = pending_q;
                `SOC_PLIC_ENABLE:    rd_word[N-1:0]           = enable_q;
                `SOC_PLIC_THRESHOLD: rd_word[`SOC_PRIO_W-1:0] = threshold_q;
                `SOC_PLIC_CLAIM:     rd_word[IDW-1:0]         = winner;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= bus.req;
        end
    end

    always_ff @(posedge clk_i) begin
        bus.rdata <= (bus.req && !bus.we) ? rd_word : '0;
    end

endmodule

/* design/soc_cfg.svh */
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// Bus and interrupt sizing
`define SOC_XLEN        32
`define SOC_NUM_SOURCES 8
`define SOC_PRIO_W      3

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------
`define SOC_CLINT_BASE  32'h0200_0000
`define SOC_CLINT_LEN   32'h000C_0000
`define SOC_PLIC_BASE   32'h0C00_0000
`define SOC_PLIC_LEN    32'h0400_0000
`define SOC_EXT_BASE    32'h8000_0000
`define SOC_EXT_LEN     32'h4000_0000

// CLINT offsets within its region
`define SOC_CLINT_MSIP        32'h0000_0000
`define SOC_CLINT_MTIMECMP_LO 32'h0000_4000
`define SOC_CLINT_MTIMECMP_HI 32'h0000_4004
`define SOC_CLINT_MTIME_LO    32'h0000_BFF8
`define SOC_CLINT_MTIME_HI    32'h0000_BFFC

// PLIC offsets, priorities sit at 4 bytes per source
`define SOC_PLIC_PRIO      32'h0000_0000
`define SOC_PLIC_PENDING   32'h0000_1000
`define SOC_PLIC_ENABLE    32'h0000_2000
`define SOC_PLIC_THRESHOLD 32'h0020_0000
`define SOC_PLIC_CLAIM     32'h0020_0004

`endif

/* flist.f */
+incdir+design
design/bus_pkg.sv
design/intr_pkg.sv
design/periph_bus_if.sv
design/bus_decoder.sv
design/clint.sv
design/plic.sv
design/periph_subsystem.sv
verification/tb_periph_subsystem.sv

/* verification/tb_periph_subsystem.sv */
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_periph_subsystem;

    localparam bus_pkg::word_t EXT_PATTERN = 32'h5A5A_C3C3;
    localparam int MAX_CYCLES = 4000;

    logic               clk_i = 1'b0;
    logic               ndmreset_n;
    logic               req_i;
    logic               we_i;
    bus_pkg::word_t     addr_i;
    bus_pkg::word_t     wdata_i;
    logic               gnt_o;
    logic               rvalid_o;
    bus_pkg::word_t     rdata_o;
    logic               err_o;
    logic               ext_req_o;
    logic               ext_we_o;
    bus_pkg::word_t     ext_addr_o;
    bus_pkg::word_t     ext_wdata_o;
    logic               ext_rvalid_i;
    bus_pkg::word_t     ext_rdata_i;
    intr_pkg::src_vec_t irq_sources_i;
    logic               timer_irq_o;
    logic               ipi_o;
    logic               eip_o;

    integer seed = 43;
    int     cycles = 0;
    int     ext_pulses = 0;
    logic   in_flight = 1'b0;

    periph_subsystem u_dut (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    // Master-side view of the single outstanding request
    always @(posedge clk_i) begin
        if (req_i && gnt_o) begin
            in_flight <= 1'b1;
        end else if (rvalid_o) begin
            in_flight <= 1'b0;
        end
    end

    task automatic fail(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic logic in_window(input bus_pkg::word_t a, input bus_pkg::word_t base,
                                       input bus_pkg::word_t len);
        return (a - base) < len;
    endfunction

    function automatic logic fixed_latency(input bus_pkg::word_t a);
        return in_window(a, `SOC_CLINT_BASE, `SOC_CLINT_LEN) ||
               in_window(a, `SOC_PLIC_BASE, `SOC_PLIC_LEN);
    endfunction

    function automatic logic unmapped(input bus_pkg::word_t a);
        return !fixed_latency(a) && !in_window(a, `SOC_EXT_BASE, `SOC_EXT_LEN);
    endfunction

    // ----------------------------------------------------------------------
    // Protocol checks
    // ----------------------------------------------------------------------
    a_fixed_lat: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        (req_i && gnt_o && fixed_latency(addr_i)) |=> (rvalid_o && !err_o))
        else fail("CLINT/PLIC response not one cycle after acceptance");
    a_gnt_low: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        in_flight |-> !gnt_o)
        else fail("gnt_o high while a request is outstanding");
    a_unmapped: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        (req_i && gnt_o && unmapped(addr_i)) |-> (!ext_req_o ##1 (rvalid_o && err_o)))
        else fail("unmapped access without error response");
    a_err_data: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        err_o |-> (rvalid_o && rdata_o == '0))
        else fail("error response with nonzero rdata or no rvalid");
    a_ext_fields: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        ext_req_o |-> (ext_addr_o == addr_i && ext_we_o == we_i &&
                       ext_wdata_o == wdata_i && in_window(addr_i, `SOC_EXT_BASE, `SOC_EXT_LEN)))
        else fail("external request fields differ from the master request");
    a_ext_resp: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        ext_rvalid_i |-> (rvalid_o && rdata_o == ext_rdata_i && !err_o))
        else fail("external response not forwarded in the same cycle");

    // External responder model
    always @(negedge clk_i) begin
        int d;
        bus_pkg::word_t a;
        ext_rvalid_i <= 1'b0;
        ext_rdata_i  <= '0;
        // Look for a request just after the falling edge
        #1;
        if (ext_req_o) begin
            ext_pulses++;
            a = ext_addr_o;
            d = $unsigned($random(seed)) % 8;
            repeat (d) @(negedge clk_i);
            @(negedge clk_i);
            ext_rvalid_i <= 1'b1;
            ext_rdata_i  <= a ^ EXT_PATTERN;
        end
    end

    task automatic bus_access(input logic we, input bus_pkg::word_t addr,
                              input bus_pkg::word_t wdata, output bus_pkg::word_t rdata,
                              output logic err);
        @(negedge clk_i);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wdata_i <= wdata;
        #1;
        while (!gnt_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        req_i <= 1'b0;
        #1;
        while (!rvalid_o) begin
            @(negedge clk_i);
            #1;
        end
        rdata = rdata_o;
        err   = err_o;
    endtask

    task automatic bus_write(input bus_pkg::word_t addr, input bus_pkg::word_t wdata);
        bus_pkg::word_t r;
        logic e;
        bus_access(1'b1, addr, wdata, r, e);
    endtask

    task automatic read_mtime(output bus_pkg::dword_u t, output int at);
        logic e;
        bus_access(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME_LO, '0, t.word.lo, e);
        at = cycles;
        bus_access(1'b0, `SOC_CLINT_BASE + `SOC_CLINT_MTIME_HI, '0, t.word.hi, e);
    endtask

    // PLIC reference model of the claim rule
    intr_pkg::prio_t prio_tab [`SOC_NUM_SOURCES] = '{0, 2, 5, 5, 1, 3, 6, 4};
    localparam logic [7:0] ENABLE_MASK = 8'h7E;
    localparam int THRESHOLD = 2;

    function automatic int expected_winner(input logic [7:0] pend);
        int best;
        int id;
        best = THRESHOLD;
        id   = 0;
        for (int i = 1; i < `SOC_NUM_SOURCES; i++) begin
            if (pend[i] && ENABLE_MASK[i] && prio_tab[i] > best) begin
                best = prio_tab[i];
                id   = i;
            end
        end
        return id;
    endfunction

    initial begin
        bus_pkg::dword_u t0;
        bus_pkg::dword_u t1;
        bus_pkg::dword_u cmp;
        bus_pkg::word_t  r;
        bus_pkg::word_t  a;
        logic            e;
        logic            w;
        logic [7:0]      pend;
        int              c0;
        int              c1;
        int              n;
        int              exp_id;

        ndmreset_n    = 1'b0;
        req_i         = 1'b0;
        we_i          = 1'b0;
        addr_i        = '0;
        wdata_i       = '0;
        ext_rvalid_i  = 1'b0;
        ext_rdata_i   = '0;
        irq_sources_i = '0;
        repeat (3) @(negedge clk_i);
        ndmreset_n <= 1'b1;
        @(negedge clk_i);
        #1;
        assert (gnt_o && !rvalid_o && !err_o && !ext_req_o && !timer_irq_o && !ipi_o && !eip_o)
            else fail("outputs not at reset values");

        // ------------------------------------------------------------------
        // CLINT software interrupt and time
        // ------------------------------------------------------------------
        bus_write(`SOC_CLINT_BASE + `SOC_CLINT_MSIP, 32'd1);
        assert (ipi_o) else fail("ipi_o not raised by msip write");
        bus_write(`SOC_CLINT_BASE + `SOC_CLINT_MSIP, 32'd0);
        assert (!ipi_o) else fail("ipi_o not lowered by msip write");

        read_mtime(t0, c0);
        repeat (40) @(negedge clk_i);
        read_mtime(t1, c1);
        n = c1 - c0;
        assert ((t1.count - t0.count) <= n / 2 + 1 && (t1.count - t0.count) + 1 >= n / 2)
            else fail($sformatf("mtime advanced %0d in %0d cycles", t1.count - t0.count, n));

        // Timer interrupt
        cmp.count = t1.count + 20;
        bus_write(`SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_LO, cmp.word.lo);
        bus_write(`SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_HI, cmp.word.hi);
        assert (!timer_irq_o) else fail("timer_irq_o high before mtimecmp reached");
        n = 0;
        while (!timer_irq_o && n < 50) begin
            @(negedge clk_i);
            #1;
            n++;
        end
        assert (timer_irq_o) else fail("timer_irq_o did not rise within 50 cycles");
        bus_write(`SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_LO, '1);
        bus_write(`SOC_CLINT_BASE + `SOC_CLINT_MTIMECMP_HI, '1);
        assert (!timer_irq_o) else fail("timer_irq_o not lowered by mtimecmp write");

        // ------------------------------------------------------------------
        // PLIC arbitration
        // ------------------------------------------------------------------
        for (int i = 1; i < `SOC_NUM_SOURCES; i++) begin
            bus_write(`SOC_PLIC_BASE + `SOC_PLIC_PRIO + 4 * i, prio_tab[i]);
        end
        bus_write(`SOC_PLIC_BASE + `SOC_PLIC_ENABLE, ENABLE_MASK);
        bus_write(`SOC_PLIC_BASE + `SOC_PLIC_THRESHOLD, THRESHOLD);
        pend = 8'hFE;
        @(negedge clk_i);
        irq_sources_i <= pend;
        repeat (2) @(negedge clk_i);
        #1;
        do begin
            exp_id = expected_winner(pend);
            assert (eip_o == (exp_id != 0)) else fail("eip_o disagrees with pending state");
            bus_access(1'b0, `SOC_PLIC_BASE + `SOC_PLIC_CLAIM, '0, r, e);
            assert (r == 0 || prio_tab[r] > THRESHOLD)
                else fail("claimed a source at or below threshold");
            assert (r == exp_id)
                else fail($sformatf("claim returned %0d, expected %0d", r, exp_id));
            if (exp_id != 0) begin
                pend[exp_id] = 1'b0;
                @(negedge clk_i);
                irq_sources_i <= pend;
                bus_write(`SOC_PLIC_BASE + `SOC_PLIC_CLAIM, exp_id);
                @(negedge clk_i);
                #1;
            end
        end while (exp_id != 0);
        assert (!eip_o) else fail("eip_o high with nothing to claim");
        @(negedge clk_i);
        irq_sources_i <= '0;

        // ------------------------------------------------------------------
        // External pass-through
        // ------------------------------------------------------------------
        for (int k = 0; k < 12; k++) begin
            a  = `SOC_EXT_BASE | ($random(seed) & 32'h3FFF_FFFC);
            w  = $random(seed);
            c0 = ext_pulses;
            bus_access(w, a, $random(seed), r, e);
            assert (r == (a ^ EXT_PATTERN) && !e)
                else fail($sformatf("external data %h for address %h", r, a));
            assert (ext_pulses == c0 + 1) else fail("ext_req_o did not pulse exactly once");
        end

        // Unmapped addresses
        for (int k = 0; k < 4; k++) begin
            a  = k[0] ? 32'h4000_0000 : 32'h0000_1000;
            c0 = ext_pulses;
            bus_access(k[1], a, 32'hDEAD_BEEF, r, e);
            assert (e && r == '0) else fail($sformatf("no error response for %h", a));
            assert (ext_pulses == c0) else fail("ext_req_o pulsed for an unmapped address");
        end

        repeat (4) @(negedge clk_i);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
